// ==== bus_pkg.sv ====
`default_nettype none

package bus_pkg;

	localparam int DATA_W  = 32;
	localparam int ADDR_W  = 32;
	localparam int N_SLOTS = 8;
	localparam int SLOT_W  = $clog2(N_SLOTS);

	typedef logic [DATA_W-1:0]  data_t;
	typedef logic [ADDR_W-1:0]  addr_t;
	// one bit per slave slot
	typedef logic [N_SLOTS-1:0] sel_t;
	typedef logic [SLOT_W-1:0]  slot_t;

endpackage

`default_nettype wire

// ==== cmd_pkg.sv ====
`default_nettype none

package cmd_pkg;

	typedef enum logic {
		OP_READ,
		OP_WRITE
	} op_e;

	typedef enum logic [1:0] {
		MS_IDLE,
		MS_REQ,
		MS_DONE
	} mstate_e;

	typedef enum logic {
		RESP_OK,
		RESP_TIMEOUT
	} resp_e;

endpackage

`default_nettype wire

// ==== bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface bus_if;
	import bus_pkg::*;

	addr_t addr;
	data_t wdata;
	logic  we;
	logic  stb;
	data_t rdata;
	logic  ack;

	modport fabric (
		output addr, wdata, we, stb,
		input  rdata, ack
	);

	modport slave (
		input  addr, wdata, we, stb,
		output rdata, ack
	);

endinterface

`default_nettype wire

// ==== bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus (
	input  wire bus_pkg::addr_t m_addr_i,
	input  wire bus_pkg::data_t m_wdata_i,
	input  wire logic           m_we_i,
	input  wire bus_pkg::sel_t  m_sel_i,
	output bus_pkg::data_t      m_rdata_o,
	output logic                m_ack_o,
	bus_if.fabric               slv [bus_pkg::N_SLOTS]
);
	import bus_pkg::*;

	data_t            slot_rdata [N_SLOTS];
	logic [N_SLOTS-1:0] slot_ack;

	// broadcast to every slot, strobe from its own select bit
	for (genvar i = 0; i < N_SLOTS; i++) begin : g_slot
		assign slv[i].addr  = m_addr_i;
		assign slv[i].wdata = m_wdata_i;
		assign slv[i].we    = m_we_i;
		assign slv[i].stb   = m_sel_i[i];

		assign slot_rdata[i] = slv[i].rdata;
		assign slot_ack[i]   = slv[i].ack;
	end

	// return path from the selected slot only
	// zero or multi-bit select gives nothing back
	always_comb begin
		m_rdata_o = '0;
		m_ack_o   = 1'b0;
		for (int i = 0; i < N_SLOTS; i++) begin
			if (m_sel_i == (sel_t'(1) << i)) begin
				m_rdata_o = slot_rdata[i];
				m_ack_o   = slot_ack[i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== bus_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_master #(
	parameter int ACK_TIMEOUT = 16
) (
	input  wire logic           clk_i,
	input  wire logic           rst_n_i,
	input  wire logic           cmd_valid_i,
	input  wire cmd_pkg::op_e   cmd_op_i,
	input  wire bus_pkg::slot_t cmd_slot_i,
	input  wire bus_pkg::addr_t cmd_addr_i,
	input  wire bus_pkg::data_t cmd_wdata_i,
	input  wire bus_pkg::data_t m_rdata_i,
	input  wire logic           m_ack_i,
	output bus_pkg::addr_t      m_addr_o,
	output bus_pkg::data_t      m_wdata_o,
	output logic                m_we_o,
	output bus_pkg::sel_t       m_sel_o,
	output logic                busy_o,
	output logic                done_o,
	output bus_pkg::data_t      rdata_o,
	output cmd_pkg::resp_e      resp_o
);
	import bus_pkg::*;
	import cmd_pkg::*;

	localparam int CNT_W = $clog2(ACK_TIMEOUT + 1);

	mstate_e          state;
	logic [CNT_W-1:0] cnt;
	logic             accept;
	logic             req;
	logic             timeout;

	op_e   op_q;
	slot_t slot_q;
	addr_t addr_q;
	data_t wdata_q;
	data_t rdata_q;
	resp_e resp_q;

	assign accept  = (state == MS_IDLE) && cmd_valid_i;
	assign req     = (state == MS_REQ);
	assign timeout = (cnt == CNT_W'(ACK_TIMEOUT));

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state  <= MS_IDLE;
			cnt    <= '0;
			busy_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				MS_IDLE: begin
					if (cmd_valid_i) begin
						state  <= MS_REQ;
						busy_o <= 1'b1;
						cnt    <= '0;
					end
				end
				MS_REQ: begin
					if (m_ack_i || timeout)
						state <= MS_DONE;
					else
						cnt <= cnt + 1'b1;
				end
				MS_DONE: begin
					// done pulse and busy release land together
					state  <= MS_IDLE;
					busy_o <= 1'b0;
					done_o <= 1'b1;
				end
				default: state <= MS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			op_q    <= cmd_op_i;
			slot_q  <= cmd_slot_i;
			addr_q  <= cmd_addr_i;
			wdata_q <= cmd_wdata_i;
		end
		if (req && m_ack_i) begin
			rdata_q <= m_rdata_i;
			resp_q  <= RESP_OK;
		end else if (req && timeout) begin
			rdata_q <= '0;
			resp_q  <= RESP_TIMEOUT;
		end
	end

	// bus is only driven while a request is open
	assign m_sel_o   = req ? (sel_t'(1) << slot_q) : '0;
	assign m_addr_o  = req ? addr_q : '0;
	assign m_wdata_o = req ? wdata_q : '0;
	assign m_we_o    = req && (op_q == OP_WRITE);

	assign rdata_o = rdata_q;
	assign resp_o  = resp_q;

endmodule

`default_nettype wire

// ==== bus_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_ram #(
	parameter int DEPTH = 64
) (
	input  wire logic clk_i,
	input  wire logic rst_n_i,
	bus_if.slave      slv
);
	import bus_pkg::*;

	localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	data_t            mem [DEPTH];
	data_t            rdata_q;
	logic             ack_q;
	logic             hit;
	logic [IDX_W-1:0] idx;

	// first cycle of a strobe only
	assign hit = slv.stb && !ack_q;
	// word address, byte offset dropped
	assign idx = IDX_W'(slv.addr[ADDR_W-1:2] % DEPTH);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= hit;
	end

	always_ff @(posedge clk_i) begin
		if (hit && slv.we)
			mem[idx] <= slv.wdata;
		if (hit)
			rdata_q <= mem[idx];
	end

	assign slv.rdata = rdata_q;
	assign slv.ack   = ack_q;

endmodule

`default_nettype wire

// ==== bus_gpio.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_gpio (
	input  wire logic           clk_i,
	input  wire logic           rst_n_i,
	input  wire bus_pkg::data_t gpio_i,
	output bus_pkg::data_t      gpio_o,
	bus_if.slave                slv
);
	import bus_pkg::*;

	localparam logic [ADDR_W-3:0] W_OUT = '0;
	localparam logic [ADDR_W-3:0] W_IN  = (ADDR_W-2)'(1);

	data_t             out_q;
	data_t             in_meta;
	data_t             in_sync;
	data_t             rdata_q;
	logic              ack_q;
	logic              hit;
	logic [ADDR_W-3:0] word;

	assign hit  = slv.stb && !ack_q;
	assign word = slv.addr[ADDR_W-1:2];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
			out_q <= '0;
		end else begin
			ack_q <= hit;
			// writes to the input word fall through
			if (hit && slv.we && (word == W_OUT))
				out_q <= slv.wdata;
		end
	end

	// two-flop synchronizer on the pins
	always_ff @(posedge clk_i) begin
		in_meta <= gpio_i;
		in_sync <= in_meta;
	end

	always_ff @(posedge clk_i) begin
		if (hit) begin
			case (word)
				W_OUT:   rdata_q <= out_q;
				W_IN:    rdata_q <= in_sync;
				default: rdata_q <= '0;
			endcase
		end
	end

	assign slv.rdata = rdata_q;
	assign slv.ack   = ack_q;
	assign gpio_o    = out_q;

endmodule

`default_nettype wire

// ==== soc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_top #(
	parameter int ACK_TIMEOUT = 16,
	parameter int RAM0_DEPTH  = 64,
	parameter int RAM1_DEPTH  = 16
) (
	input  wire logic           clk_i,
	input  wire logic           rst_n_i,
	input  wire logic           cmd_valid_i,
	input  wire cmd_pkg::op_e   cmd_op_i,
	input  wire bus_pkg::slot_t cmd_slot_i,
	input  wire bus_pkg::addr_t cmd_addr_i,
	input  wire bus_pkg::data_t cmd_wdata_i,
	input  wire bus_pkg::data_t gpio_i,
	output logic                busy_o,
	output logic                done_o,
	output bus_pkg::data_t      rdata_o,
	output cmd_pkg::resp_e      resp_o,
	output bus_pkg::data_t      gpio_o
);
	import bus_pkg::*;

	localparam int FIRST_EMPTY = 3;

	addr_t m_addr;
	data_t m_wdata;
	logic  m_we;
	sel_t  m_sel;
	data_t m_rdata;
	logic  m_ack;

	bus_if slots [N_SLOTS] ();

	bus_master #(
		.ACK_TIMEOUT(ACK_TIMEOUT)
	) u_bus_master (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.cmd_valid_i(cmd_valid_i),
		.cmd_op_i   (cmd_op_i),
		.cmd_slot_i (cmd_slot_i),
		.cmd_addr_i (cmd_addr_i),
		.cmd_wdata_i(cmd_wdata_i),
		.m_rdata_i  (m_rdata),
		.m_ack_i    (m_ack),
		.m_addr_o   (m_addr),
		.m_wdata_o  (m_wdata),
		.m_we_o     (m_we),
		.m_sel_o    (m_sel),
		.busy_o     (busy_o),
		.done_o     (done_o),
		.rdata_o    (rdata_o),
		.resp_o     (resp_o)
	);

	bus u_bus (
		.m_addr_i (m_addr),
		.m_wdata_i(m_wdata),
		.m_we_i   (m_we),
		.m_sel_i  (m_sel),
		.m_rdata_o(m_rdata),
		.m_ack_o  (m_ack),
		.slv      (slots)
	);

	bus_ram #(.DEPTH(RAM0_DEPTH)) u_ram0 (
		.clk_i  (clk_i),
		.rst_n_i(rst_n_i),
		.slv    (slots[0])
	);

	bus_gpio u_gpio (
		.clk_i  (clk_i),
		.rst_n_i(rst_n_i),
		.gpio_i (gpio_i),
		.gpio_o (gpio_o),
		.slv    (slots[1])
	);

	bus_ram #(.DEPTH(RAM1_DEPTH)) u_ram1 (
		.clk_i  (clk_i),
		.rst_n_i(rst_n_i),
		.slv    (slots[2])
	);

	// unpopulated slots never answer, the master times out
	for (genvar i = FIRST_EMPTY; i < N_SLOTS; i++) begin : g_empty
		assign slots[i].rdata = '0;
		assign slots[i].ack   = 1'b0;
	end

endmodule

`default_nettype wire

// ==== tb_clk.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk #(
	parameter real PERIOD_NS = 4.0
) (
	output logic clk_o
);
	initial clk_o = 1'b0;

	always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== soc_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_asserts (
	input wire logic           clk_i,
	input wire logic           rst_n_i,
	input wire logic           done_i,
	input wire logic           ack_i,
	input wire logic           timeout_i,
	input wire bus_pkg::sel_t  sel_i,
	input wire bus_pkg::addr_t addr_i
);
	int fail_cnt = 0;

	// done is a single-cycle pulse
	a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		done_i |=> !done_i)
	else begin
		$error("done_o high on two consecutive cycles");
		fail_cnt++;
	end

	a_sel_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$onehot0(sel_i))
	else begin
		$error("m_sel_o has more than one bit set");
		fail_cnt++;
	end

	// open request holds its slot and address
	a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(sel_i != '0 && !ack_i && !timeout_i) |=> ($stable(sel_i) && $stable(addr_i)))
	else begin
		$error("m_sel_o or m_addr_o moved while waiting for ack");
		fail_cnt++;
	end

endmodule

bind bus_master soc_asserts u_soc_asserts (
	.clk_i    (clk_i),
	.rst_n_i  (rst_n_i),
	.done_i   (done_o),
	.ack_i    (m_ack_i),
	.timeout_i(timeout),
	.sel_i    (m_sel_o),
	.addr_i   (m_addr_o)
);

`default_nettype wire

// ==== tb_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_soc;
	import bus_pkg::*;
	import cmd_pkg::*;

	localparam int ACK_TIMEOUT = 16;
	localparam int DONE_LIMIT  = 64;
	localparam int HIT_LAT     = 4;

	logic  clk_i;
	logic  rst_n_i;
	logic  cmd_valid_i;
	op_e   cmd_op_i;
	slot_t cmd_slot_i;
	addr_t cmd_addr_i;
	data_t cmd_wdata_i;
	data_t gpio_i;
	logic  busy_o;
	logic  done_o;
	data_t rdata_o;
	resp_e resp_o;
	data_t gpio_o;

	data_t  gpio_model;
	data_t  fill [8];
	data_t  rd;
	resp_e  rs;
	int     lat;
	integer seed;

	tb_clk #(.PERIOD_NS(4.0)) u_tb_clk (.clk_o(clk_i));

	soc_top #(
		.ACK_TIMEOUT(ACK_TIMEOUT),
		.RAM0_DEPTH (64),
		.RAM1_DEPTH (16)
	) u_soc_top (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.cmd_valid_i(cmd_valid_i),
		.cmd_op_i   (cmd_op_i),
		.cmd_slot_i (cmd_slot_i),
		.cmd_addr_i (cmd_addr_i),
		.cmd_wdata_i(cmd_wdata_i),
		.gpio_i     (gpio_i),
		.busy_o     (busy_o),
		.done_o     (done_o),
		.rdata_o    (rdata_o),
		.resp_o     (resp_o),
		.gpio_o     (gpio_o)
	);

	task automatic stop_run();
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_resp(input string name, input resp_e got, input resp_e exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_gpio(input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("FAIL gpio_o got %h expected %h", got, exp);
			stop_run();
		end
	endtask

	// rising edges from the accepting edge to the one that sees done
	task automatic check_latency(input int got, input resp_e exp_rs);
		int exp;
		exp = (exp_rs == RESP_OK) ? HIT_LAT : ACK_TIMEOUT + 3;
		if (got != exp) begin
			$display("FAIL done_o latency got %h expected %h", got, exp);
			stop_run();
		end
	endtask

	task automatic run_cmd(input op_e op, input slot_t slot, input addr_t addr,
			input data_t wdata, input bit stray);
		cmd_op_i    = op;
		cmd_slot_i  = slot;
		cmd_addr_i  = addr;
		cmd_wdata_i = wdata;
		cmd_valid_i = 1'b1;
		@(negedge clk_i);
		check_flag("busy_o", busy_o, 1'b1);
		// stray command aims at the next word with inverted data
		if (stray) begin
			cmd_addr_i  = addr + 4;
			cmd_wdata_i = ~wdata;
		end
		lat = 1;
		while (!done_o) begin
			cmd_valid_i = stray && (lat == 1);
			@(negedge clk_i);
			lat++;
			if (lat > DONE_LIMIT) begin
				$display("no done pulse arrived within %0d cycles of the command", DONE_LIMIT);
				stop_run();
			end
		end
		cmd_valid_i = 1'b0;
		check_flag("busy_o", busy_o, 1'b0);
		rd = rdata_o;
		rs = resp_o;
	endtask

	task automatic run_vector(input op_e op, input slot_t slot, input addr_t addr,
			input data_t wdata, input data_t pins, input data_t exp_rd, input resp_e exp_rs);
		gpio_i = pins;
		// pins need two edges through the synchronizer
		repeat (3) @(negedge clk_i);
		run_cmd(op, slot, addr, wdata, 1'b0);
		check_resp("resp_o", rs, exp_rs);
		check_latency(lat, exp_rs);
		if (op == OP_READ)
			check_data("rdata_o", rd, exp_rd);
		if (op == OP_WRITE && slot == slot_t'(1) && addr[ADDR_W-1:2] == '0)
			gpio_model = wdata;
		check_gpio(gpio_o, gpio_model);
	endtask

	task automatic read_vectors();
		int          fd;
		int          n;
		string       line;
		logic [31:0] op_v;
		logic [31:0] slot_v;
		addr_t       addr_v;
		data_t       wdata_v;
		data_t       pin_v;
		data_t       exp_rd;
		logic [31:0] rs_v;
		fd = $fopen("soc_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open soc_tests.txt");
			stop_run();
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%h %h %h %h %h %h %h",
					op_v, slot_v, addr_v, wdata_v, pin_v, exp_rd, rs_v);
				if (n != 7) begin
					$display("malformed vector line in soc_tests.txt: %s", line);
					stop_run();
				end
				run_vector(op_e'(op_v[0]), slot_t'(slot_v), addr_v, wdata_v,
					pin_v, exp_rd, resp_e'(rs_v[0]));
			end
		end
		$fclose(fd);
	endtask

	task automatic random_fill();
		for (int i = 0; i < 8; i++) begin
			fill[i] = $random(seed);
			run_cmd(OP_WRITE, slot_t'(0), addr_t'(32'h40 + 4 * i), fill[i], 1'b0);
			check_resp("resp_o", rs, RESP_OK);
		end
		for (int i = 0; i < 8; i++) begin
			run_cmd(OP_READ, slot_t'(0), addr_t'(32'h40 + 4 * i), '0, 1'b0);
			check_resp("resp_o", rs, RESP_OK);
			check_latency(lat, RESP_OK);
			check_data("rdata_o", rd, fill[i]);
		end
	endtask

	task automatic stray_command();
		run_cmd(OP_WRITE, slot_t'(0), 32'h84, 32'h0000_5a5a, 1'b0);
		run_cmd(OP_WRITE, slot_t'(0), 32'h80, 32'h1234_5678, 1'b1);
		repeat (8) begin
			@(negedge clk_i);
			if (done_o || busy_o) begin
				$display("a command given while busy started a second transfer");
				stop_run();
			end
		end
		run_cmd(OP_READ, slot_t'(0), 32'h84, '0, 1'b0);
		check_data("rdata_o", rd, 32'h0000_5a5a);
		run_cmd(OP_READ, slot_t'(0), 32'h80, '0, 1'b0);
		check_data("rdata_o", rd, 32'h1234_5678);
	endtask

	task automatic timeout_read();
		// previous read left a nonzero word on rdata_o
		run_cmd(OP_READ, slot_t'(5), 32'h10, '0, 1'b0);
		check_resp("resp_o", rs, RESP_TIMEOUT);
		check_latency(lat, RESP_TIMEOUT);
		check_data("rdata_o", rd, '0);
	endtask

	initial begin
		rst_n_i     = 1'b0;
		cmd_valid_i = 1'b0;
		cmd_op_i    = OP_READ;
		cmd_slot_i  = '0;
		cmd_addr_i  = '0;
		cmd_wdata_i = '0;
		gpio_i      = '0;
		gpio_model  = '0;
		seed        = 28;
		repeat (2) @(negedge clk_i);
		rst_n_i = 1'b1;
		check_gpio(gpio_o, '0);
		read_vectors();
		random_fill();
		stray_command();
		timeout_read();
		if (u_soc_top.u_bus_master.u_soc_asserts.fail_cnt != 0) begin
			$display("protocol assertions failed %0d times",
				u_soc_top.u_bus_master.u_soc_asserts.fail_cnt);
			stop_run();
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== soc_bus.f ====
bus_pkg.sv
cmd_pkg.sv
bus_if.sv
bus.sv
bus_master.sv
bus_ram.sv
bus_gpio.sv
soc_top.sv
tb_clk.sv
soc_asserts.sv
tb_soc.sv

// ==== soc_tests.txt ====
# columns: op slot addr wdata gpio_i exp_rdata exp_resp
# op 0 is read and 1 is write; resp 0 is ok and 1 is timeout; rdata checked on reads only
1 0 00000010 deadbeef 00000000 00000000 0
0 0 00000010 00000000 00000000 deadbeef 0
1 2 00000010 cafef00d 00000000 00000000 0
0 2 00000010 00000000 00000000 cafef00d 0
0 0 00000010 00000000 00000000 deadbeef 0
1 2 00000004 11112222 00000000 00000000 0
0 2 00000044 00000000 00000000 11112222 0
1 1 00000000 a5a5c3c3 00000000 00000000 0
0 1 00000000 00000000 00000000 a5a5c3c3 0
0 1 00000004 00000000 13579bdf 13579bdf 0
1 1 00000004 ffffffff 13579bdf 00000000 0
0 1 00000000 00000000 13579bdf a5a5c3c3 0
0 1 00000008 00000000 13579bdf 00000000 0
0 7 00000000 00000000 13579bdf 00000000 1
1 7 00000020 0badc0de 13579bdf 00000000 1
0 0 00000010 00000000 13579bdf deadbeef 0
